// File: src/mmioPkg.sv
// MMIO client package
// Register map, reset defaults and the shared bus and configuration structs
// for the shell MMIO client

package mmioPkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned dataWidth     = 8;    // Bus data byte
  localparam int unsigned pageAddrWidth = 7;    // In-page offset, bit 7 picks the half
  localparam int unsigned roleWidth     = 16;   // ROLE read and write words
  localparam int unsigned regCount      = 128;  // Lower half of the address space

  // ----------------------------------------
  // Register byte addresses
  // ----------------------------------------
  localparam logic [pageAddrWidth-1:0] cfgVpdId     = 7'h00;  // Build ID
  localparam logic [pageAddrWidth-1:0] cfgVpdVer    = 7'h01;  // Version
  localparam logic [pageAddrWidth-1:0] cfgVpdExt    = 7'h03;
  localparam logic [pageAddrWidth-1:0] phyStat      = 7'h10;  // Read-only status pins
  localparam logic [pageAddrWidth-1:0] phyEth0      = 7'h11;  // Three tuning bytes
  localparam logic [pageAddrWidth-1:0] ly2Mac0      = 7'h22;  // MAC, MSB first
  localparam logic [pageAddrWidth-1:0] ly3Ip0       = 7'h34;  // IP, MSB first
  localparam logic [pageAddrWidth-1:0] roleRd0      = 7'h40;  // Read-only ROLE word
  localparam logic [pageAddrWidth-1:0] roleWr0      = 7'h42;  // ROLE write word
  localparam logic [pageAddrWidth-1:0] diagScratch0 = 7'h70;
  localparam logic [pageAddrWidth-1:0] diagCtrl     = 7'h74;  // Loopback enables
  localparam logic [pageAddrWidth-1:0] pageSel      = 7'h7F;  // Window page

  // ----------------------------------------
  // Reset default values
  // ----------------------------------------
  localparam logic [dataWidth-1:0] idUser     = 8'h3C;
  localparam logic [dataWidth-1:0] idSuper    = 8'h3D;
  localparam logic [dataWidth-1:0] defVersion = 8'h01;
  localparam logic [dataWidth-1:0] defVpdExt  = 8'h33;
  localparam logic [3*dataWidth-1:0] defEth0    = 24'h41_05_05;  // Swing 4, eq on, cursors 5
  localparam logic [4*dataWidth-1:0] defScratch = 32'hDE_AD_BE_EF;

  // ----------------------------------------
  // Shared structs
  // ----------------------------------------
  typedef struct packed {
    logic                     csN;   // Chip select, active low
    logic                     weN;   // Write enable, active low
    logic                     oeN;   // Output enable, active low
    logic [pageAddrWidth:0]   addr;  // Bit 7 splits registers from the window
    logic [dataWidth-1:0]     data;  // Write data from the controller
  } emifBus_t;

  // One decoded access toward a datapath
  typedef struct packed {
    logic                     wrEn;
    logic                     rdEn;
    logic [pageAddrWidth-1:0] addr;
    logic [dataWidth-1:0]     wrData;
  } regAccess_t;

  typedef struct packed {
    logic       rxEqualizerMode;  // 0x11 bit 0
    logic [3:0] txDriverSwing;    // 0x11 bits 7..4
    logic [4:0] txPreCursor;      // 0x12 bits 4..0
    logic [4:0] txPostCursor;     // 0x13 bits 4..0
    logic       pcsLoopbackEn;    // 0x74 bit 0
    logic       macLoopbackEn;    // 0x74 bit 1
  } eth0Cfg_t;

  typedef struct packed {
    logic [6*dataWidth-1:0] macAddress;
    logic [4*dataWidth-1:0] ipAddress;
  } ntsCfg_t;

  // Status pins, read at 0x10 bits 0..3
  typedef struct packed {
    logic mc0InitCalComplete;
    logic mc1InitCalComplete;
    logic eth0CoreReady;
    logic eth0QpllLock;
  } shellStatus_t;

  // Reset value of one register byte
  function automatic logic [dataWidth-1:0] defaultByte(
    input logic [pageAddrWidth-1:0] addr,
    input logic                     superUser
  );
    logic [dataWidth-1:0] val;
    val = '0;  // Everything else clears
    case (addr)
      cfgVpdId:            val = superUser ? idSuper : idUser;
      cfgVpdVer:           val = defVersion;
      cfgVpdExt:           val = defVpdExt;
      phyEth0:             val = defEth0[23:16];
      phyEth0 + 7'd1:      val = defEth0[15:8];
      phyEth0 + 7'd2:      val = defEth0[7:0];
      diagScratch0:        val = defScratch[31:24];
      diagScratch0 + 7'd1: val = defScratch[23:16];
      diagScratch0 + 7'd2: val = defScratch[15:8];
      diagScratch0 + 7'd3: val = defScratch[7:0];
      default:             val = '0;
    endcase
    return val;
  endfunction

endpackage

// File: src/emifAccessCtrl.sv
// EMIF access controller
// Splits bus strobes into register or window accesses, remembers which
// source was read and steers the returned byte onto the data pins

module emifAccessCtrl #(
  parameter bit superUser = 1'b0  // Window into the paged memory exists
) (
  input  logic                               shlClk,
  input  logic                               reset,
  input  mmioPkg::emifBus_t                  bus,
  input  logic [mmioPkg::dataWidth-1:0]      regRdData,  // Registered by the register file
  input  logic [mmioPkg::dataWidth-1:0]      memRdData,  // Registered by the memory
  output mmioPkg::regAccess_t                regAcc,
  output mmioPkg::regAccess_t                memAcc,
  output logic [mmioPkg::dataWidth-1:0]      dataOut,
  output logic                               dataOe
);

  localparam int halfBit = mmioPkg::pageAddrWidth;  // Address bit 7

  // Which datapath answered the last read
  typedef enum logic [1:0] {
    srcNone,  // Reset or blocked window, returns 0x00
    srcReg,
    srcMem
  } rdSrc_t;

  logic   busActive;  // Strobe this cycle
  logic   regHit;     // Lower half
  logic   memHit;     // Upper half, window present
  rdSrc_t rdSrc;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign busActive = !bus.csN;
  assign regHit    = busActive && !bus.addr[halfBit];
  assign memHit    = busActive && bus.addr[halfBit] && superUser;  // Dropped without window

  always_comb
  begin
    // Register file side
    regAcc.wrEn   = regHit && !bus.weN;
    regAcc.rdEn   = regHit && bus.weN;
    regAcc.addr   = bus.addr[halfBit-1:0];
    regAcc.wrData = bus.data;
    // Memory side shares offset and data
    memAcc.wrEn   = memHit && !bus.weN;
    memAcc.rdEn   = memHit && bus.weN;
    memAcc.addr   = bus.addr[halfBit-1:0];
    memAcc.wrData = bus.data;
  end

  // ----------------------------------------
  // Read source tracking
  // ----------------------------------------
  // Updated only on reads, so the pins hold across writes and idle cycles
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      rdSrc <= srcNone;
    end
    else if (busActive && bus.weN)
    begin
      if (regHit)
        rdSrc <= srcReg;
      else if (memHit)
        rdSrc <= srcMem;
      else
        rdSrc <= srcNone;  // Upper half without memory
    end
  end

  // Return mux
  always_comb
  begin
    case (rdSrc)
      srcReg:  dataOut = regRdData;
      srcMem:  dataOut = memRdData;
      default: dataOut = '0;
    endcase
  end

  // Pins driven only when the controller asks and never in reset
  assign dataOe = !bus.oeN && !reset;

endmodule

// File: src/ctrlRegFile.sv
// Control and status register file
// 128 bytes with reset defaults, a read-only overlay for the status pins
// and the ROLE read word, and the field outputs toward the shell

module ctrlRegFile #(
  parameter bit superUser = 1'b0  // Selects the ID byte at 0x00
) (
  input  logic                                shlClk,
  input  logic                                reset,
  input  mmioPkg::regAccess_t                 regAcc,
  input  mmioPkg::shellStatus_t               status,
  input  logic [mmioPkg::roleWidth-1:0]       roleIn,
  output logic [mmioPkg::dataWidth-1:0]       regRdData,
  output logic [mmioPkg::dataWidth-1:0]       pageSelect,
  output mmioPkg::eth0Cfg_t                   eth0Cfg,
  output mmioPkg::ntsCfg_t                    ntsCfg,
  output logic [mmioPkg::roleWidth-1:0]       roleOut
);

  localparam int addrW = mmioPkg::pageAddrWidth;
  localparam int dataW = mmioPkg::dataWidth;

  logic [dataW-1:0] regs [mmioPkg::regCount];  // Byte storage
  logic [dataW-1:0] statusByte;                // Pins as seen at 0x10
  logic [dataW-1:0] rdByte;                    // Byte before the read register
  logic             readOnly;                  // Access hits a status byte

  // ----------------------------------------
  // Read-only overlay
  // ----------------------------------------
  assign statusByte = {
    4'b0000,                     // Upper nibble reads 0
    status.eth0QpllLock,         // Bit 3
    status.eth0CoreReady,        // Bit 2
    status.mc1InitCalComplete,   // Bit 1
    status.mc0InitCalComplete    // Bit 0
  };

  assign readOnly = (regAcc.addr == mmioPkg::phyStat) ||
                    (regAcc.addr == mmioPkg::roleRd0) ||
                    (regAcc.addr == mmioPkg::roleRd0 + 7'd1);

  // ----------------------------------------
  // Byte storage
  // ----------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      // Every byte back to its map default
      for (int i = 0; i < mmioPkg::regCount; i++)
      begin
        regs[i] <= mmioPkg::defaultByte(addrW'(i), superUser);
      end
    end
    else if (regAcc.wrEn && !readOnly)
    begin
      regs[regAcc.addr] <= regAcc.wrData;  // Status bytes silently drop writes
    end
  end

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb
  begin
    rdByte = regs[regAcc.addr];  // Plain RAM behaviour by default
    case (regAcc.addr)
      mmioPkg::phyStat:        rdByte = statusByte;
      mmioPkg::roleRd0:        rdByte = roleIn[15:8];  // High byte first
      mmioPkg::roleRd0 + 7'd1: rdByte = roleIn[7:0];
      default:                 rdByte = regs[regAcc.addr];
    endcase
  end

  // Byte held until the next register read
  always_ff @(posedge shlClk)
  begin
    if (regAcc.rdEn)
    begin
      regRdData <= rdByte;
    end
  end

  // ----------------------------------------
  // Field outputs
  // ----------------------------------------
  // PHY tuning and loopback
  always_comb
  begin
    eth0Cfg.rxEqualizerMode = regs[mmioPkg::phyEth0][0];
    eth0Cfg.txDriverSwing   = regs[mmioPkg::phyEth0][7:4];
    eth0Cfg.txPreCursor     = regs[mmioPkg::phyEth0 + 7'd1][4:0];
    eth0Cfg.txPostCursor    = regs[mmioPkg::phyEth0 + 7'd2][4:0];
    eth0Cfg.pcsLoopbackEn   = regs[mmioPkg::diagCtrl][0];
    eth0Cfg.macLoopbackEn   = regs[mmioPkg::diagCtrl][1];
  end

  // Addresses, lowest byte address lands in the MSB
  always_comb
  begin
    for (int b = 0; b < 6; b++)
    begin
      ntsCfg.macAddress[(5-b)*dataW +: dataW] = regs[mmioPkg::ly2Mac0 + addrW'(b)];
    end
    for (int b = 0; b < 4; b++)
    begin
      ntsCfg.ipAddress[(3-b)*dataW +: dataW] = regs[mmioPkg::ly3Ip0 + addrW'(b)];
    end
  end

  // ROLE word, 0x42 is the high byte
  assign roleOut = {regs[mmioPkg::roleWr0], regs[mmioPkg::roleWr0 + 7'd1]};

  assign pageSelect = regs[mmioPkg::pageSel];  // Window page

endmodule

// File: src/pageMemory.sv
// Paged byte memory
// Sits behind the upper address window, one 128-byte page at a time,
// with a synchronous write and a registered read

module pageMemory #(
  parameter int memBytes = 2048  // Power of two, 16 pages by default
) (
  input  logic                           shlClk,
  input  mmioPkg::regAccess_t            memAcc,
  input  logic [mmioPkg::dataWidth-1:0]  pageSelect,
  output logic [mmioPkg::dataWidth-1:0]  memRdData
);

  localparam int memAddrWidth = $clog2(memBytes);

  logic [mmioPkg::dataWidth-1:0] mem [memBytes];  // No reset on content
  logic [memAddrWidth-1:0]       memAddr;

  // Page bits above the memory size fall off here
  assign memAddr = memAddrWidth'({pageSelect, memAcc.addr});

  // ----------------------------------------
  // Single port access
  // ----------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (memAcc.wrEn)
    begin
      mem[memAddr] <= memAcc.wrData;
    end
  end

  // Read byte held until the next window read
  always_ff @(posedge shlClk)
  begin
    if (memAcc.rdEn)
    begin
      memRdData <= mem[memAddr];
    end
  end

endmodule

// File: src/mmioClient.sv
// MMIO client top level
// EMIF access control, the control and status register file and the
// optional paged memory window for the shell

module mmioClient #(
  parameter bit superUser = 1'b1,  // Super build with memory window
  parameter int memBytes  = 2048   // Window memory size
) (
  input  logic                                shlClk,
  input  logic                                reset,
  // Controller bus
  input  mmioPkg::emifBus_t                   bus,
  output logic [mmioPkg::dataWidth-1:0]       dataOut,
  output logic                                dataOe,
  // Shell status and control
  input  mmioPkg::shellStatus_t               status,
  output mmioPkg::eth0Cfg_t                   eth0Cfg,
  output mmioPkg::ntsCfg_t                    ntsCfg,
  // ROLE words
  input  logic [mmioPkg::roleWidth-1:0]       roleIn,
  output logic [mmioPkg::roleWidth-1:0]       roleOut
);

  mmioPkg::regAccess_t           regAcc;      // Lower half accesses
  mmioPkg::regAccess_t           memAcc;      // Upper half accesses
  logic [mmioPkg::dataWidth-1:0] regRdData;
  logic [mmioPkg::dataWidth-1:0] memRdData;
  logic [mmioPkg::dataWidth-1:0] pageSelect;  // From byte 0x7F

  // ----------------------------------------
  // Bus decode and return mux
  // ----------------------------------------
  emifAccessCtrl #(
    .superUser (superUser)
  ) accessCtrl (
    .shlClk    (shlClk),
    .reset     (reset),
    .bus       (bus),
    .regRdData (regRdData),
    .memRdData (memRdData),
    .regAcc    (regAcc),
    .memAcc    (memAcc),
    .dataOut   (dataOut),
    .dataOe    (dataOe)
  );

  // ----------------------------------------
  // Control and status registers
  // ----------------------------------------
  ctrlRegFile #(
    .superUser  (superUser)
  ) regFile (
    .shlClk     (shlClk),
    .reset      (reset),
    .regAcc     (regAcc),
    .status     (status),
    .roleIn     (roleIn),
    .regRdData  (regRdData),
    .pageSelect (pageSelect),
    .eth0Cfg    (eth0Cfg),
    .ntsCfg     (ntsCfg),
    .roleOut    (roleOut)
  );

  // Window memory, idle when the window is blocked
  pageMemory #(
    .memBytes   (memBytes)
  ) pageMem (
    .shlClk     (shlClk),
    .memAcc     (memAcc),
    .pageSelect (pageSelect),
    .memRdData  (memRdData)
  );

endmodule

// File: testbench/mmioClient_asserts.sv
// EMIF access controller checks
// Bound into the controller, watches the output enable and the decode

module mmioClient_asserts (
  input logic                shlClk,
  input logic                reset,
  input mmioPkg::emifBus_t   bus,
  input mmioPkg::regAccess_t regAcc,
  input mmioPkg::regAccess_t memAcc,
  input logic                dataOe
);

  logic regBusy;        // Register side active
  logic memBusy;        // Window side active
  int   failCount = 0;  // Failed assertions so far

  assign regBusy = regAcc.wrEn || regAcc.rdEn;
  assign memBusy = memAcc.wrEn || memAcc.rdEn;

  // Pins stay off in reset
  oeInReset: assert property (@(posedge shlClk) reset |-> !dataOe)
    else
    begin
      failCount++;
      $error("dataOe active while reset is high");
    end

  // One datapath per strobe
  oneTarget: assert property (@(posedge shlClk) !(regBusy && memBusy))
    else
    begin
      failCount++;
      $error("register and window access in the same cycle");
    end

  noStrayAccess: assert property (@(posedge shlClk) bus.csN |-> !(regBusy || memBusy))
    else
    begin
      failCount++;
      $error("access decoded while chip select is high");
    end

endmodule

bind emifAccessCtrl mmioClient_asserts accessChecks (
  .shlClk (shlClk),
  .reset  (reset),
  .bus    (bus),
  .regAcc (regAcc),
  .memAcc (memAcc),
  .dataOe (dataOe)
);

// File: testbench/tbMmioClient.sv
// MMIO client testbench
// Directed tests over the EMIF strobes, with register and window
// read-back and checks on the field outputs toward the shell

module tbMmioClient;

  localparam int clkPeriod   = 8;
  localparam int resetCycles = 3;
  localparam int testTotal   = 5;
  localparam int testBudget  = 1500;  // Cycles per test, memory test is longest

  logic                  shlClk;
  logic                  reset;
  mmioPkg::emifBus_t     bus;
  mmioPkg::shellStatus_t status;
  logic [15:0]           roleIn;
  logic [7:0]            dataOut;
  logic                  dataOe;
  mmioPkg::eth0Cfg_t     eth0Cfg;
  mmioPkg::ntsCfg_t      ntsCfg;
  logic [15:0]           roleOut;

  integer     seed = 32'hd1a3_62cb;  // Random data source
  int         errorCount;
  int         checkCount;
  int         failedTests;
  int         testStartErrors;
  int         assertFails;           // Bound checker failures
  logic [7:0] pageData [2][128];     // Expected window bytes, pages 2 and 5

  mmioClient #(
    .superUser (1'b1),
    .memBytes  (2048)
  ) DUT (
    .shlClk  (shlClk),
    .reset   (reset),
    .bus     (bus),
    .dataOut (dataOut),
    .dataOe  (dataOe),
    .status  (status),
    .eth0Cfg (eth0Cfg),
    .ntsCfg  (ntsCfg),
    .roleIn  (roleIn),
    .roleOut (roleOut)
  );

  // ----------------------------------------
  // Clock and watchdog
  // ----------------------------------------
  initial
  begin
    shlClk = 1'b0;
    forever #(clkPeriod / 2) shlClk = ~shlClk;
  end

  initial
  begin
    #((resetCycles + testTotal * testBudget) * clkPeriod);
    $display("watchdog expired with tests still running at time %0t", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ----------------------------------------
  // Bus drivers
  // ----------------------------------------
  function automatic mmioPkg::emifBus_t idleBus();
    mmioPkg::emifBus_t b;
    b     = '0;
    b.csN = 1'b1;
    b.weN = 1'b1;
    b.oeN = 1'b1;
    return b;
  endfunction

  task automatic busWrite(input logic [7:0] addr, input logic [7:0] data);
    @(posedge shlClk);
    bus.csN  <= 1'b0;
    bus.weN  <= 1'b0;
    bus.oeN  <= 1'b1;
    bus.addr <= addr;
    bus.data <= data;
    @(posedge shlClk);  // DUT takes the write here
    bus <= idleBus();
    @(negedge shlClk);  // Field outputs settled
  endtask

  // One cycle read latency, byte shows after the sampling edge
  task automatic busRead(input logic [7:0] addr, output logic [7:0] data);
    @(posedge shlClk);
    bus.csN  <= 1'b0;
    bus.weN  <= 1'b1;
    bus.oeN  <= 1'b0;
    bus.addr <= addr;
    bus.data <= '0;
    @(posedge shlClk);  // Datapath registers the byte
    bus <= idleBus();
    @(negedge shlClk);
    data = dataOut;
  endtask

  // ----------------------------------------
  // Checking and bookkeeping
  // ----------------------------------------
  task automatic checkValue(input string what, input logic [63:0] got,
                            input logic [63:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      $display("mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic readExpect(input logic [7:0] addr, input logic [7:0] exp);
    logic [7:0] got;
    busRead(addr, got);
    checkValue($sformatf("byte 0x%02h", addr), 64'(got), 64'(exp));
  endtask

  task automatic endTest(input string name);
    if (errorCount == testStartErrors)
      $display("test %s: ok", name);
    else
    begin
      $display("test %s: %0d errors", name, errorCount - testStartErrors);
      failedTests++;
    end
    testStartErrors = errorCount;
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic testResetDefaults();
    readExpect(8'h00, 8'h3D);  // Super build ID
    readExpect(8'h01, 8'h01);
    readExpect(8'h03, 8'h33);
    readExpect(8'h11, 8'h41);
    readExpect(8'h12, 8'h05);
    readExpect(8'h13, 8'h05);
    readExpect(8'h70, 8'hDE);
    readExpect(8'h71, 8'hAD);
    readExpect(8'h72, 8'hBE);
    readExpect(8'h73, 8'hEF);
    checkValue("rxEqualizerMode", 64'(eth0Cfg.rxEqualizerMode), 64'd1);
    checkValue("txDriverSwing", 64'(eth0Cfg.txDriverSwing), 64'd4);
    checkValue("txPreCursor", 64'(eth0Cfg.txPreCursor), 64'd5);
    checkValue("txPostCursor", 64'(eth0Cfg.txPostCursor), 64'd5);
    checkValue("pcsLoopbackEn", 64'(eth0Cfg.pcsLoopbackEn), 64'd0);
    checkValue("macLoopbackEn", 64'(eth0Cfg.macLoopbackEn), 64'd0);
  endtask

  task automatic testAddressWrites();
    logic [7:0]  mac [6];
    logic [7:0]  ip [4];
    logic [47:0] expMac;
    logic [31:0] expIp;
    expMac = '0;
    expIp  = '0;
    for (int i = 0; i < 6; i++)
    begin
      mac[i] = 8'($random(seed));
      busWrite(8'h22 + 8'(i), mac[i]);
      expMac = {expMac[39:0], mac[i]};  // Lowest address ends on top
    end
    for (int i = 0; i < 4; i++)
    begin
      ip[i] = 8'($random(seed));
      busWrite(8'h34 + 8'(i), ip[i]);
      expIp = {expIp[23:0], ip[i]};
    end
    for (int i = 0; i < 6; i++)
      readExpect(8'h22 + 8'(i), mac[i]);
    for (int i = 0; i < 4; i++)
      readExpect(8'h34 + 8'(i), ip[i]);
    checkValue("macAddress", 64'(ntsCfg.macAddress), 64'(expMac));
    checkValue("ipAddress", 64'(ntsCfg.ipAddress), 64'(expIp));
    // Both loopbacks on
    busWrite(8'h74, 8'h03);
    checkValue("pcsLoopbackEn", 64'(eth0Cfg.pcsLoopbackEn), 64'd1);
    checkValue("macLoopbackEn", 64'(eth0Cfg.macLoopbackEn), 64'd1);
    readExpect(8'h74, 8'h03);
  endtask

  task automatic testStatusRole();
    logic [15:0] roleWord;
    logic [15:0] roleSet;
    roleWord = 16'($random(seed));
    roleSet  = 16'($random(seed));
    @(posedge shlClk);
    status.mc0InitCalComplete <= 1'b1;
    status.mc1InitCalComplete <= 1'b0;
    status.eth0CoreReady      <= 1'b1;
    status.eth0QpllLock       <= 1'b1;
    roleIn                    <= roleWord;
    busWrite(8'h10, 8'hFF);              // Dropped, status is read-only
    busWrite(8'h40, ~roleWord[15:8]);    // Dropped too
    readExpect(8'h10, 8'h0D);            // Qpll, core ready, mc0
    readExpect(8'h40, roleWord[15:8]);
    readExpect(8'h41, roleWord[7:0]);
    busWrite(8'h42, roleSet[15:8]);
    busWrite(8'h43, roleSet[7:0]);
    checkValue("roleOut", 64'(roleOut), 64'(roleSet));
    readExpect(8'h42, roleSet[15:8]);
  endtask

  task automatic testPagedMemory();
    busWrite(8'h7F, 8'h02);
    for (int i = 0; i < 128; i++)
    begin
      pageData[0][i] = 8'($random(seed));
      busWrite(8'h80 + 8'(i), pageData[0][i]);
    end
    busWrite(8'h7F, 8'h05);
    for (int i = 0; i < 128; i++)
    begin
      pageData[1][i] = ~pageData[0][i];  // Differs from page 2 everywhere
      busWrite(8'h80 + 8'(i), pageData[1][i]);
    end
    readExpect(8'h7F, 8'h05);
    for (int i = 0; i < 128; i++)
      readExpect(8'h80 + 8'(i), pageData[1][i]);
    busWrite(8'h7F, 8'h02);
    for (int i = 0; i < 128; i++)
      readExpect(8'h80 + 8'(i), pageData[0][i]);
    // Register half untouched by window writes
    readExpect(8'h00, 8'h3D);
    readExpect(8'h03, 8'h33);
    readExpect(8'h11, 8'h41);
    readExpect(8'h70, 8'hDE);
  endtask

  task automatic testOutputEnable();
    @(posedge shlClk);
    bus.oeN <= 1'b0;
    @(negedge shlClk);
    checkValue("dataOe with oeN low", 64'(dataOe), 64'd1);
    @(posedge shlClk);
    bus.oeN <= 1'b1;
    @(negedge shlClk);
    checkValue("dataOe with oeN high", 64'(dataOe), 64'd0);
    // Last read byte holds through writes and idle cycles
    readExpect(8'h71, 8'hAD);
    busWrite(8'h73, 8'h5A);
    checkValue("dataOut after register write", 64'(dataOut), 64'hAD);
    busWrite(8'h90, 8'hC3);
    checkValue("dataOut after window write", 64'(dataOut), 64'hAD);
    repeat (3) @(negedge shlClk);
    checkValue("dataOut after idle bus", 64'(dataOut), 64'hAD);
    readExpect(8'h73, 8'h5A);  // Next read replaces it
  endtask

  // ----------------------------------------
  // Sequence
  // ----------------------------------------
  initial
  begin
    bus             = idleBus();
    bus.oeN         = 1'b0;  // Controller asks for the pins during reset
    status          = '0;
    roleIn          = '0;
    reset           = 1'b1;
    errorCount      = 0;
    checkCount      = 0;
    failedTests     = 0;
    testStartErrors = 0;
    assertFails     = 0;
    @(posedge shlClk);
    @(negedge shlClk);
    // Pins off and return byte clear while reset is high
    checkValue("dataOe in reset", 64'(dataOe), 64'd0);
    checkValue("dataOut in reset", 64'(dataOut), 64'h00);
    repeat (resetCycles - 1) @(posedge shlClk);
    reset   <= 1'b0;
    bus.oeN <= 1'b1;
    @(negedge shlClk);

    testResetDefaults();
    endTest("reset defaults");
    testAddressWrites();
    endTest("address writes");
    testStatusRole();
    endTest("status and role");
    testPagedMemory();
    endTest("paged memory");
    testOutputEnable();
    endTest("output enable and hold");

    assertFails = DUT.accessCtrl.accessChecks.failCount;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             testTotal, failedTests, checkCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: all.f
src/mmioPkg.sv
src/emifAccessCtrl.sv
src/ctrlRegFile.sv
src/pageMemory.sv
src/mmioClient.sv
testbench/mmioClient_asserts.sv
testbench/tbMmioClient.sv

// File: run.sh
#!/bin/sh
# Build and run the MMIO client testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tbMmioClient -f all.f
./obj_dir/VtbMmioClient | tee sim.log
grep -q "SIMULATION PASSED" sim.log
